// ==== quickq_pkg.sv ====
`default_nettype none

package quickq_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////

  localparam int depth  = 16;  // queue capacity
  localparam int addr_w = 4;   // memory address
  localparam int cnt_w  = 5;   // occupancy, 0 .. depth
  localparam int key_w  = 16;
  localparam int tag_w  = 16;

  //////////////////////////////////////////////////////////////////////
  // queue entry
  //////////////////////////////////////////////////////////////////////

  // key orders the queue, tag rides along untouched
  typedef struct packed {
    logic [key_w-1:0] key;
    logic [tag_w-1:0] tag;
  } entry_t;

  //////////////////////////////////////////////////////////////////////
  // datapath opcodes
  //////////////////////////////////////////////////////////////////////

  // hold register update
  typedef enum logic [2:0] {
    MODE_NONE     = 3'd0,  // keep
    MODE_LOAD_IN  = 3'd1,  // take enq_entry
    MODE_LOAD_MEM = 3'd2   // take memory read data
  } dp_mode_t;

  // memory write data source
  typedef enum logic {
    WSEL_HOLD  = 1'b0,
    WSEL_RDATA = 1'b1
  } wsel_t;

  // controller states
  typedef enum logic [3:0] {
    IDLE            = 4'd0,
    ENQ_FILL        = 4'd1,
    ENQ_READ        = 4'd2,
    ENQ_COMPARE     = 4'd3,
    ENQ_SWAP        = 4'd4,
    ENQ_NEXT        = 4'd5,
    ENQ_TAIL        = 4'd6,
    DEQ_READ        = 4'd7,
    DEQ_PRESENT     = 4'd8,
    DEQ_SHIFT_READ  = 4'd9,
    DEQ_SHIFT_WRITE = 4'd10,
    DEQ_DONE        = 4'd11
  } ctrl_state_t;

  // controller commands to store and swap unit
  typedef struct packed {
    logic     idx_clr;  // index back to zero
    logic     idx_inc;
    logic     rd_en;
    logic     rd_next;  // read at index + 1
    logic     we;       // write at index
    wsel_t    wsel;
    dp_mode_t mode;
    logic     cnt_inc;
    logic     cnt_dec;
  } dp_ctrl_t;

  // store flags back to the controller
  typedef struct packed {
    logic full;
    logic empty;
    logic at_tail;  // index == count
    logic at_last;  // index == count - 1
  } store_stat_t;

endpackage

`default_nettype wire

// ==== quickq_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module quickq_ctrl (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic                     enq,
  input  wire logic                     deq,
  input  wire quickq_pkg::store_stat_t  stat,
  input  wire logic                     swap_req,
  output quickq_pkg::dp_ctrl_t          ctrl,
  output logic                          busy,
  output logic                          deq_valid
);

  import quickq_pkg::*;

  ctrl_state_t state;
  ctrl_state_t next;

  //////////////////////////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= next;
    end
  end

  // head entry is latched by the store at the end of DEQ_PRESENT
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      deq_valid <= 1'b0;
    end
    else
    begin
      deq_valid <= (state == DEQ_PRESENT);
    end
  end

  assign busy = (state != IDLE);

  //////////////////////////////////////////////////////////////////////
  // next state and datapath commands
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    next      = state;
    ctrl      = '0;
    ctrl.wsel = WSEL_HOLD;
    ctrl.mode = MODE_NONE;

    case (state)
      IDLE:
      begin
        // index is already zero here, every operation ends with idx_clr
        if (enq)
        begin
          if (!stat.full)
          begin
            next = ENQ_FILL;
          end
        end
        else if (deq && !stat.empty)
        begin
          next = DEQ_READ;
        end
      end

      // enqueue: bubble the new entry up from address zero
      ENQ_FILL:
      begin
        ctrl.mode    = MODE_LOAD_IN;
        ctrl.idx_clr = 1'b1;
        next         = ENQ_READ;
      end

      ENQ_READ:
      begin
        if (stat.at_tail)
        begin
          next = ENQ_TAIL;  // walked past every stored entry
        end
        else
        begin
          ctrl.rd_en = 1'b1;
          next       = ENQ_COMPARE;
        end
      end

      ENQ_COMPARE:
      begin
        // strictly smaller only, equal keys stay behind older ones
        if (swap_req)
        begin
          next = ENQ_SWAP;
        end
        else
        begin
          next = ENQ_NEXT;
        end
      end

      ENQ_SWAP:
      begin
        ctrl.we   = 1'b1;
        ctrl.wsel = WSEL_HOLD;      // hold goes into memory
        ctrl.mode = MODE_LOAD_MEM;  // old entry goes into hold
        next      = ENQ_NEXT;
      end

      ENQ_NEXT:
      begin
        ctrl.idx_inc = 1'b1;
        next         = ENQ_READ;
      end

      ENQ_TAIL:
      begin
        ctrl.we      = 1'b1;
        ctrl.wsel    = WSEL_HOLD;
        ctrl.cnt_inc = 1'b1;
        ctrl.idx_clr = 1'b1;
        next         = IDLE;
      end

      // dequeue: present head, then shift the rest down
      DEQ_READ:
      begin
        ctrl.rd_en   = 1'b1;
        ctrl.idx_clr = 1'b1;  // marks the head read for the store
        next         = DEQ_PRESENT;
      end

      DEQ_PRESENT:
      begin
        next = DEQ_SHIFT_READ;  // store captures rdata this cycle
      end

      DEQ_SHIFT_READ:
      begin
        if (stat.at_last)
        begin
          next = DEQ_DONE;
        end
        else
        begin
          ctrl.rd_en   = 1'b1;
          ctrl.rd_next = 1'b1;
          next         = DEQ_SHIFT_WRITE;
        end
      end

      DEQ_SHIFT_WRITE:
      begin
        ctrl.we      = 1'b1;
        ctrl.wsel    = WSEL_RDATA;  // entry from index + 1
        ctrl.idx_inc = 1'b1;
        next         = DEQ_SHIFT_READ;
      end

      DEQ_DONE:
      begin
        ctrl.cnt_dec = 1'b1;
        ctrl.idx_clr = 1'b1;
        next         = IDLE;
      end

      default:
      begin
        next = IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== quickq_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module quickq_store (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire quickq_pkg::dp_ctrl_t      ctrl,
  input  wire quickq_pkg::entry_t        wdata,
  output quickq_pkg::entry_t             rdata,
  output quickq_pkg::store_stat_t        stat,
  output logic [quickq_pkg::cnt_w-1:0]   count,
  output quickq_pkg::entry_t             deq_entry
);

  import quickq_pkg::*;

  entry_t            mem [depth];
  logic [addr_w-1:0] idx;
  logic [addr_w-1:0] rd_addr;
  logic              head_rd;  // last cycle read the head

  //////////////////////////////////////////////////////////////////////
  // entry memory, synchronous read
  //////////////////////////////////////////////////////////////////////

  assign rd_addr = ctrl.rd_next ? idx + addr_w'(1) : idx;

  always_ff @(posedge clk)
  begin
    if (ctrl.we)
    begin
      mem[idx] <= wdata;
    end
    if (ctrl.rd_en)
    begin
      rdata <= mem[rd_addr];  // held until the next read
    end
  end

  //////////////////////////////////////////////////////////////////////
  // counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      idx     <= '0;
      count   <= '0;
      head_rd <= 1'b0;
    end
    else
    begin
      if (ctrl.idx_clr)
      begin
        idx <= '0;
      end
      else if (ctrl.idx_inc)
      begin
        idx <= idx + addr_w'(1);
      end

      if (ctrl.cnt_inc)
      begin
        count <= count + cnt_w'(1);
      end
      else if (ctrl.cnt_dec)
      begin
        count <= count - cnt_w'(1);
      end

      head_rd <= ctrl.rd_en & ctrl.idx_clr;
    end
  end

  // head entry capture, quiet cycle right after the head read
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      deq_entry <= '0;
    end
    else if (head_rd && !ctrl.rd_en && ctrl.mode == MODE_NONE)
    begin
      deq_entry <= rdata;
    end
  end

  // status flags
  assign stat.full    = (count == cnt_w'(depth));
  assign stat.empty   = (count == '0);
  assign stat.at_tail = ({1'b0, idx} == count);
  assign stat.at_last = ({1'b0, idx} == count - cnt_w'(1));

endmodule

`default_nettype wire

// ==== quickq_swap_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module quickq_swap_unit (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire quickq_pkg::dp_ctrl_t  ctrl,
  input  wire quickq_pkg::entry_t    enq_entry,
  input  wire quickq_pkg::entry_t    rdata,
  output quickq_pkg::entry_t         wdata,
  output logic                       swap_req
);

  import quickq_pkg::*;

  entry_t hold;

  //////////////////////////////////////////////////////////////////////
  // hold register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      hold <= '0;
    end
    else
    begin
      case (ctrl.mode)
        MODE_LOAD_IN:  hold <= enq_entry;  // new entry
        MODE_LOAD_MEM: hold <= rdata;      // displaced entry during a swap
        default:       hold <= hold;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // compare and write select
  //////////////////////////////////////////////////////////////////////

  // keys only, tags never take part in ordering
  assign swap_req = (hold.key < rdata.key);

  always_comb
  begin
    case (ctrl.wsel)
      WSEL_RDATA: wdata = rdata;  // shift down
      default:    wdata = hold;
    endcase
  end

endmodule

`default_nettype wire

// ==== quickq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module quickq_top (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic                     enq,
  input  wire quickq_pkg::entry_t       enq_entry,
  input  wire logic                     deq,
  output quickq_pkg::entry_t            deq_entry,
  output logic                          deq_valid,
  output logic                          busy,
  output logic                          full,
  output logic                          empty,
  output logic [quickq_pkg::cnt_w-1:0]  count
);

  import quickq_pkg::*;

  dp_ctrl_t    ctrl;
  store_stat_t stat;
  entry_t      rdata;
  entry_t      wdata;
  logic        swap_req;

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  quickq_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .enq       (enq),
    .deq       (deq),
    .stat      (stat),
    .swap_req  (swap_req),
    .ctrl      (ctrl),
    .busy      (busy),
    .deq_valid (deq_valid)
  );

  //////////////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////////////

  quickq_store u_store (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .wdata     (wdata),
    .rdata     (rdata),
    .stat      (stat),
    .count     (count),
    .deq_entry (deq_entry)
  );

  quickq_swap_unit u_swap (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .enq_entry (enq_entry),
    .rdata     (rdata),
    .wdata     (wdata),
    .swap_req  (swap_req)
  );

  assign full  = stat.full;
  assign empty = stat.empty;

endmodule

`default_nettype wire

// ==== quickq_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module quickq_checker (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      enq,
  input  wire logic                      deq,
  input  wire logic                      deq_valid,
  input  wire logic                      busy,
  input  wire logic                      full,
  input  wire logic                      empty,
  input  wire logic [quickq_pkg::cnt_w-1:0] count,
  input  wire quickq_pkg::dp_ctrl_t      ctrl,
  input  wire quickq_pkg::ctrl_state_t   state
);

  import quickq_pkg::*;

  logic accept;  // strobe taken this cycle, enq wins over deq

  assign accept = !busy && (enq ? !full : (deq && !empty));

  valid_single: assert property (@(posedge clk) disable iff (rst)
    deq_valid |=> !deq_valid)
    else $error("deq_valid high in two consecutive cycles");

  // a full queue only takes writes while shifting down
  no_write_full: assert property (@(posedge clk) disable iff (rst)
    (ctrl.we && full) |-> (state == DEQ_SHIFT_WRITE))
    else $error("memory write while full outside the dequeue shift");

  count_range: assert property (@(posedge clk) disable iff (rst)
    count <= cnt_w'(depth))
    else $error("count above queue depth");

  // dropped or absent strobes leave the queue idle
  idle_stays: assert property (@(posedge clk) disable iff (rst)
    (!busy && !accept) |=> !busy)
    else $error("busy rose without an accepted command");

endmodule

bind quickq_top quickq_checker u_checker (
  .clk       (clk),
  .rst       (rst),
  .enq       (enq),
  .deq       (deq),
  .deq_valid (deq_valid),
  .busy      (busy),
  .full      (full),
  .empty     (empty),
  .count     (count),
  .ctrl      (ctrl),
  .state     (u_ctrl.state)
);

`default_nettype wire

// ==== quickq_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module quickq_monitor (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic                          enq,
  input  wire logic                          deq,
  input  wire quickq_pkg::entry_t            deq_entry,
  input  wire logic                          deq_valid,
  input  wire logic                          busy,
  input  wire logic                          full,
  input  wire logic                          empty,
  input  wire logic [quickq_pkg::cnt_w-1:0]  count,
  input  wire logic                          check,
  input  string                              name,
  input  wire logic                          exp_data,
  input  wire quickq_pkg::entry_t            exp_entry,
  input  wire logic [quickq_pkg::cnt_w-1:0]  exp_count,
  input  wire logic                          exp_full,
  input  wire logic                          exp_empty,
  input  wire logic                          report,
  output int                                 errors
);

  import quickq_pkg::*;

  entry_t got_entry;   // last entry seen with deq_valid
  int     valid_seen;  // deq_valid pulses in the current test
  int     lat_cyc;
  int     last_lat;
  int     tests;
  int     bad_tests;
  int     err_total;
  logic   lat_run;     // accepted deq waiting for deq_valid
  logic   acc_prev;    // command accepted at the previous edge
  logic   rise_miss;
  logic   test_bad;

  initial
  begin
    errors    = 0;
    err_total = 0;
    tests     = 0;
    bad_tests = 0;
    last_lat  = 0;
  end

  task automatic report_mismatch(input string field, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("[FAIL] %0s %0s expected %0h actual %0h", name, field, exp_v, act_v);
    err_total++;
    test_bad = 1'b1;
  endtask

  task automatic report_problem(input string what);
    $display("test %0s: %0s", name, what);
    err_total++;
    test_bad = 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // watch the ports, compare on the check strobe
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (rst)
    begin
      valid_seen = 0;
      lat_run    = 1'b0;
      lat_cyc    = 0;
      acc_prev   = 1'b0;
      rise_miss  = 1'b0;
      test_bad   = 1'b0;
    end
    else
    begin
      if (acc_prev && !busy)
        rise_miss = 1'b1;  // busy must follow an accepted command
      acc_prev = !busy && (enq ? !full : (deq && !empty));

      if (deq_valid)
      begin
        valid_seen++;
        got_entry = deq_entry;
        if (!lat_run)
          report_problem("deq_valid pulsed with no accepted deq in flight");
        else
          last_lat = lat_cyc + 1;  // edges since the sampling edge
        lat_run = 1'b0;
      end
      else if (lat_run)
      begin
        lat_cyc++;
      end

      if (!busy && deq && !enq && !empty)
      begin
        lat_run = 1'b1;  // deq accepted at this edge
        lat_cyc = 0;
      end

      if (check)
      begin
        if (rise_miss)
          report_problem("busy did not rise after an accepted command");
        if (count != exp_count)
          report_mismatch("count", 32'(exp_count), 32'(count));
        if (full != exp_full)
          report_mismatch("full", 32'(exp_full), 32'(full));
        if (empty != exp_empty)
          report_mismatch("empty", 32'(exp_empty), 32'(empty));
        if (exp_data)
        begin
          if (valid_seen == 0)
            report_problem("accepted deq returned no deq_valid");
          else
          begin
            if (got_entry != exp_entry)
              report_mismatch("entry", exp_entry, got_entry);
            if (last_lat != 3)
              report_mismatch("deq latency", 32'd3, last_lat);
          end
          if (valid_seen > 1)
            report_problem("more than one deq_valid for a single deq");
        end
        else if (valid_seen != 0)
        begin
          report_problem("deq_valid seen where no data was expected");
        end

        tests++;
        if (test_bad)
          bad_tests++;
        $display("test %0s: %0s", name, test_bad ? "mismatch" : "ok");
        valid_seen = 0;
        rise_miss  = 1'b0;
        test_bad   = 1'b0;
      end

      if (report)
        $display("summary: %0d tests, %0d ok, %0d mismatched, %0d errors",
                 tests, tests - bad_tests, bad_tests, err_total);
    end
    errors <= err_total;
  end

endmodule

`default_nettype wire

// ==== quickq_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module quickq_tb;

  import quickq_pkg::*;

  logic             clk;
  logic             rst;
  logic             enq;
  logic             deq;
  entry_t           enq_entry;
  entry_t           deq_entry;
  logic             deq_valid;
  logic             busy;
  logic             full;
  logic             empty;
  logic [cnt_w-1:0] count;

  // expected values handed to the monitor
  logic             check;
  logic             report;
  logic             exp_data;
  logic             exp_full;
  logic             exp_empty;
  logic [cnt_w-1:0] exp_count;
  entry_t           exp_entry;
  string            test_name;
  int               errors;

  // contents of quickq_cases.txt
  string            case_name [$];
  string            case_op [$];
  entry_t           case_in [$];
  entry_t           case_exp [$];
  logic [cnt_w-1:0] case_count [$];
  logic             case_full [$];
  logic             case_empty [$];

  int cycles;
  int limit;

  quickq_top quickq_top_inst (
    .clk       (clk),
    .rst       (rst),
    .enq       (enq),
    .enq_entry (enq_entry),
    .deq       (deq),
    .deq_entry (deq_entry),
    .deq_valid (deq_valid),
    .busy      (busy),
    .full      (full),
    .empty     (empty),
    .count     (count)
  );

  quickq_monitor u_monitor (
    .clk       (clk),
    .rst       (rst),
    .enq       (enq),
    .deq       (deq),
    .deq_entry (deq_entry),
    .deq_valid (deq_valid),
    .busy      (busy),
    .full      (full),
    .empty     (empty),
    .count     (count),
    .check     (check),
    .name      (test_name),
    .exp_data  (exp_data),
    .exp_entry (exp_entry),
    .exp_count (exp_count),
    .exp_full  (exp_full),
    .exp_empty (exp_empty),
    .report    (report),
    .errors    (errors)
  );

  always #4 clk = ~clk;  // 8 ns period

  //////////////////////////////////////////////////////////////////////
  // cases file and stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic read_cases();
    int               fd;
    int               got;
    string            line;
    string            nm;
    string            op;
    logic [key_w-1:0] key;
    logic [tag_w-1:0] tag;
    logic [key_w-1:0] ekey;
    logic [tag_w-1:0] etag;
    logic [cnt_w-1:0] ecount;
    logic             efull;
    logic             eempty;
    fd = $fopen("quickq_cases.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open quickq_cases.txt");
      return;
    end
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() > 0 && line[0] != "#")
      begin
        got = $sscanf(line, "%s %s %h %h %h %h %d %d %d", nm, op, key, tag,
                      ekey, etag, ecount, efull, eempty);
        if (got == 9)
        begin
          case_name.push_back(nm);
          case_op.push_back(op);
          case_in.push_back({key, tag});
          case_exp.push_back({ekey, etag});
          case_count.push_back(ecount);
          case_full.push_back(efull);
          case_empty.push_back(eempty);
        end
      end
    end
    $fclose(fd);
  endtask

  // one strobe, wait for the queue to settle, then hand over the check
  task automatic run_case(input int i, input logic [cnt_w-1:0] prev_count);
    @(posedge clk);
    enq_entry <= case_in[i];
    enq       <= (case_op[i] == "enq");
    deq       <= (case_op[i] == "deq");
    @(posedge clk);
    enq <= 1'b0;
    deq <= 1'b0;
    repeat (3) @(posedge clk);  // a dropped strobe never raises busy
    while (busy)
      @(posedge clk);
    test_name <= case_name[i];
    exp_entry <= case_exp[i];
    exp_count <= case_count[i];
    exp_full  <= case_full[i];
    exp_empty <= case_empty[i];
    exp_data  <= (case_op[i] == "deq") && (prev_count != '0);  // deq on empty is ignored
    check     <= 1'b1;
    @(posedge clk);
    check <= 1'b0;
  endtask

  initial
  begin
    logic [cnt_w-1:0] prev;
    clk       = 1'b0;
    rst       = 1'b1;
    enq       = 1'b0;
    deq       = 1'b0;
    enq_entry = '0;
    check     = 1'b0;
    report    = 1'b0;
    exp_data  = 1'b0;
    exp_entry = '0;
    exp_count = '0;
    exp_full  = 1'b0;
    exp_empty = 1'b0;
    test_name = "";
    cycles    = 0;
    limit     = 0;
    read_cases();
    limit = case_name.size() * (3 * depth + 10) + 20;
    repeat (5) @(posedge clk);
    rst  <= 1'b0;
    prev = '0;
    foreach (case_name[i])
    begin
      run_case(i, prev);
      prev = case_count[i];
    end
    report <= 1'b1;
    @(posedge clk);
    report <= 1'b0;
    @(posedge clk);
    if (case_name.size() > 0 && errors == 0)
    begin
      $display("Test passed");
    end
    else
    begin
      if (case_name.size() == 0)
        $display("no test cases were read");
      $display("Test failed");
    end
    $finish;
  end

  // run length guard
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit)
    begin
      $display("timeout: tests still running after %0d cycles", limit);
      $display("Test failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== quickq_top.f ====
quickq_pkg.sv
quickq_ctrl.sv
quickq_store.sv
quickq_swap_unit.sv
quickq_top.sv
quickq_checker.sv
quickq_monitor.sv
quickq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the quickq testbench with Verilator, verdict comes from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module quickq_tb \
  -f quickq_top.f -o quickq_sim > build.log 2>&1 || { cat build.log; exit 1; }
# a crash or an assertion stop also counts as a failing run
./obj_dir/quickq_sim > sim.log 2>&1 || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

// ==== quickq_cases.txt ====
# name op key tag exp_key exp_tag exp_count exp_full exp_empty
# key and tag fields in hex, count/full/empty in decimal, exp_key/exp_tag used by deq only
reset_state idle 0000 0000 0000 0000 0 0 1
deq_empty deq 0000 0000 0000 0000 0 0 1
sort_enq_0 enq 0300 00a1 0000 0000 1 0 0
sort_enq_1 enq 0100 00a2 0000 0000 2 0 0
sort_enq_2 enq 0400 00a3 0000 0000 3 0 0
sort_enq_3 enq 0200 00a4 0000 0000 4 0 0
sort_deq_0 deq 0000 0000 0100 00a2 3 0 0
sort_deq_1 deq 0000 0000 0200 00a4 2 0 0
sort_deq_2 deq 0000 0000 0300 00a1 1 0 0
sort_deq_3 deq 0000 0000 0400 00a3 0 0 1
tie_enq_0 enq 0050 00b1 0000 0000 1 0 0
tie_enq_1 enq 0090 00b4 0000 0000 2 0 0
tie_enq_2 enq 0050 00b2 0000 0000 3 0 0
tie_enq_3 enq 0050 00b3 0000 0000 4 0 0
tie_deq_0 deq 0000 0000 0050 00b1 3 0 0
tie_deq_1 deq 0000 0000 0050 00b2 2 0 0
tie_deq_2 deq 0000 0000 0050 00b3 1 0 0
tie_deq_3 deq 0000 0000 0090 00b4 0 0 1
mix_enq_0 enq 0700 00c1 0000 0000 1 0 0
mix_enq_1 enq 0300 00c2 0000 0000 2 0 0
mix_deq_0 deq 0000 0000 0300 00c2 1 0 0
mix_enq_2 enq 0500 00c3 0000 0000 2 0 0
mix_enq_3 enq 0100 00c4 0000 0000 3 0 0
mix_deq_1 deq 0000 0000 0100 00c4 2 0 0
mix_deq_2 deq 0000 0000 0500 00c3 1 0 0
mix_deq_3 deq 0000 0000 0700 00c1 0 0 1
full_enq_00 enq 1000 00d0 0000 0000 1 0 0
full_enq_01 enq 1100 00d1 0000 0000 2 0 0
full_enq_02 enq 1200 00d2 0000 0000 3 0 0
full_enq_03 enq 1300 00d3 0000 0000 4 0 0
full_enq_04 enq 1400 00d4 0000 0000 5 0 0
full_enq_05 enq 1500 00d5 0000 0000 6 0 0
full_enq_06 enq 1600 00d6 0000 0000 7 0 0
full_enq_07 enq 1700 00d7 0000 0000 8 0 0
full_enq_08 enq 1800 00d8 0000 0000 9 0 0
full_enq_09 enq 1900 00d9 0000 0000 10 0 0
full_enq_10 enq 1a00 00da 0000 0000 11 0 0
full_enq_11 enq 1b00 00db 0000 0000 12 0 0
full_enq_12 enq 1c00 00dc 0000 0000 13 0 0
full_enq_13 enq 1d00 00dd 0000 0000 14 0 0
full_enq_14 enq 1e00 00de 0000 0000 15 0 0
full_enq_15 enq 1f00 00df 0000 0000 16 1 0
full_enq_drop enq 0001 00ee 0000 0000 16 1 0
full_deq_0 deq 0000 0000 1000 00d0 15 0 0
full_deq_1 deq 0000 0000 1100 00d1 14 0 0
